// ==== Makefile ====
TOP = tb_issue_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+.
issue_pkg.sv
instr_info_if.sv
fullness_if.sv
issuer.sv
occupancy_tracker.sv
issue_unit_top.sv
tb_issue_unit.sv

// ==== fullness_if.sv ====
// full flags from the occupancy tracker to the issuer
`timescale 1ns/1ps

interface fullness_if;

  logic alu;
  logic branch;
  logic load_store;
  logic mult_div;
  logic rob;

  modport tracker (
    output alu,
    output branch,
    output load_store,
    output mult_div,
    output rob
  );

  modport issuer (
    input alu,
    input branch,
    input load_store,
    input mult_div,
    input rob
  );

endinterface

// ==== instr_info_if.sv ====
// one decoded instruction slot
`timescale 1ns/1ps

interface instr_info_if;
  import issue_pkg::*;

  xlen_t       address;
  xlen_t       immediate;
  instr_name_t instr_name;
  instr_type_t instr_type;
  regs_t       regs;
  flags_t      flags;

  modport in (
    input address,
    input immediate,
    input instr_name,
    input instr_type,
    input regs,
    input flags
  );

  modport out (
    output address,
    output immediate,
    output instr_name,
    output instr_type,
    output regs,
    output flags
  );

endinterface

// ==== issue_pkg.sv ====
// issue stage types
// instruction fields, target units and occupancy counts
`include "issue_settings.svh"

package issue_pkg;

  typedef logic [`XLEN-1:0] xlen_t;  // address, immediate

  // UNKNOWN marks a bubble
  typedef enum logic [3:0] {
    UNKNOWN = 4'd0,
    ADD     = 4'd1,
    SUB     = 4'd2,
    AND_OP  = 4'd3,
    BEQ     = 4'd4,
    JAL     = 4'd5,
    LW      = 4'd6,
    SW      = 4'd7,
    MUL     = 4'd8,
    DIV     = 4'd9
  } instr_name_t;

  // target unit, order matches the station counters
  typedef enum logic [2:0] {
    AL = 3'd0,  // alu
    BR = 3'd1,  // branch
    LS = 3'd2,  // load/store
    MD = 3'd3,  // mult/div
    XX = 3'd4   // no unit
  } instr_type_t;

  typedef logic [14:0] regs_t;  // rd, rs1, rs2 at 5 bits each
  typedef logic [3:0] flags_t;

  // sized to hold a completely full unit
  typedef logic [$clog2(`STATION_DEPTH+1)-1:0] station_count_t;
  typedef logic [$clog2(`ROB_DEPTH+1)-1:0] rob_count_t;

endpackage

// ==== issue_settings.svh ====
// issue stage settings
// data width, station and reorder buffer depths, full threshold
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// address and immediate width
`define XLEN 32

// entries per reservation station
`define STATION_DEPTH 8

// reorder buffer entries
`define ROB_DEPTH 16

// a unit is full below this many free entries
// two pairs can be in flight before a flag reacts
`define FULL_MARGIN 4

`endif

// ==== issue_unit_top.sv ====
// issue stage top, joins the issuer and the occupancy tracker
`timescale 1ns/1ps

module issue_unit_top (
  input  logic                  global_bus,
  input  logic                  reset,
  input  issue_pkg::xlen_t       in0_address,
  input  issue_pkg::xlen_t       in1_address,
  input  issue_pkg::xlen_t       in0_immediate,
  input  issue_pkg::xlen_t       in1_immediate,
  input  issue_pkg::instr_name_t in0_instr_name,
  input  issue_pkg::instr_name_t in1_instr_name,
  input  issue_pkg::instr_type_t in0_instr_type,
  input  issue_pkg::instr_type_t in1_instr_type,
  input  issue_pkg::regs_t       in0_regs,
  input  issue_pkg::regs_t       in1_regs,
  input  issue_pkg::flags_t      in0_flags,
  input  issue_pkg::flags_t      in1_flags,
  output issue_pkg::xlen_t       out0_address,
  output issue_pkg::xlen_t       out1_address,
  output issue_pkg::xlen_t       out0_immediate,
  output issue_pkg::xlen_t       out1_immediate,
  output issue_pkg::instr_name_t out0_instr_name,
  output issue_pkg::instr_name_t out1_instr_name,
  output issue_pkg::instr_type_t out0_instr_type,
  output issue_pkg::instr_type_t out1_instr_type,
  output issue_pkg::regs_t       out0_regs,
  output issue_pkg::regs_t       out1_regs,
  output issue_pkg::flags_t      out0_flags,
  output issue_pkg::flags_t      out1_flags,
  input  logic                  alu_done,
  input  logic                  branch_done,
  input  logic                  load_store_done,
  input  logic                  mult_div_done,
  input  logic [1:0]            rob_retire,
  output logic                  stop
);

  instr_info_if instr_in [2] ();
  instr_info_if instr_out [2] ();  // also read back by the tracker
  fullness_if   fullness ();

  assign instr_in[0].address    = in0_address;
  assign instr_in[0].immediate  = in0_immediate;
  assign instr_in[0].instr_name = in0_instr_name;
  assign instr_in[0].instr_type = in0_instr_type;
  assign instr_in[0].regs       = in0_regs;
  assign instr_in[0].flags      = in0_flags;
  assign instr_in[1].address    = in1_address;
  assign instr_in[1].immediate  = in1_immediate;
  assign instr_in[1].instr_name = in1_instr_name;
  assign instr_in[1].instr_type = in1_instr_type;
  assign instr_in[1].regs       = in1_regs;
  assign instr_in[1].flags      = in1_flags;

  assign out0_address    = instr_out[0].address;
  assign out0_immediate  = instr_out[0].immediate;
  assign out0_instr_name = instr_out[0].instr_name;
  assign out0_instr_type = instr_out[0].instr_type;
  assign out0_regs       = instr_out[0].regs;
  assign out0_flags      = instr_out[0].flags;
  assign out1_address    = instr_out[1].address;
  assign out1_immediate  = instr_out[1].immediate;
  assign out1_instr_name = instr_out[1].instr_name;
  assign out1_instr_type = instr_out[1].instr_type;
  assign out1_regs       = instr_out[1].regs;
  assign out1_flags      = instr_out[1].flags;

  issuer issuer_inst (
    .global_bus (global_bus),
    .reset      (reset),
    .instr_in   (instr_in),
    .instr_out  (instr_out),
    .fullness   (fullness),
    .stop       (stop)
  );

  occupancy_tracker occupancy_tracker_inst (
    .global_bus      (global_bus),
    .reset           (reset),
    .issued          (instr_out),
    .stop            (stop),
    .alu_done        (alu_done),
    .branch_done     (branch_done),
    .load_store_done (load_store_done),
    .mult_div_done   (mult_div_done),
    .rob_retire      (rob_retire),
    .fullness        (fullness)
  );

endmodule

// ==== issuer.sv ====
// issuer for an instruction pair
// registers the pair when every target has room, else raises stop and holds
`timescale 1ns/1ps

module issuer (
  input  logic       global_bus,
  input  logic       reset,
  instr_info_if.in   instr_in [2],
  instr_info_if.out  instr_out [2],
  fullness_if.issuer fullness,
  output logic       stop
);
  import issue_pkg::*;

  logic [1:0] slot_bubble;
  logic [1:0] slot_full;  // target station of the slot is full
  logic       any_bubble;
  logic       blocked;

  for (genvar i = 0; i < 2; i++) begin : gen_slot
    assign slot_bubble[i] = (instr_in[i].instr_name == UNKNOWN);

    // type XX has no station, only the rob flag applies
    assign slot_full[i] = (instr_in[i].instr_type == AL && fullness.alu) ||
                          (instr_in[i].instr_type == BR && fullness.branch) ||
                          (instr_in[i].instr_type == LS && fullness.load_store) ||
                          (instr_in[i].instr_type == MD && fullness.mult_div);

    always_ff @(posedge global_bus) begin
      if (reset || any_bubble) begin  // whole pair turns into a bubble
        instr_out[i].address    <= '0;
        instr_out[i].immediate  <= '0;
        instr_out[i].instr_name <= UNKNOWN;
        instr_out[i].instr_type <= XX;
        instr_out[i].regs       <= '0;
        instr_out[i].flags      <= '0;
      end else if (!blocked) begin
        instr_out[i].address    <= instr_in[i].address;
        instr_out[i].immediate  <= instr_in[i].immediate;
        instr_out[i].instr_name <= instr_in[i].instr_name;
        instr_out[i].instr_type <= instr_in[i].instr_type;
        instr_out[i].regs       <= instr_in[i].regs;
        instr_out[i].flags      <= instr_in[i].flags;
      end
    end

    // a stalled edge leaves the last issued pair in place
    a_hold_on_stop: assert property (
      @(posedge global_bus) disable iff (reset)
      stop |-> $stable({instr_out[i].address, instr_out[i].immediate,
                        instr_out[i].instr_name, instr_out[i].instr_type,
                        instr_out[i].regs, instr_out[i].flags})
    );
  end

  assign any_bubble = |slot_bubble;
  assign blocked    = (|slot_full) || fullness.rob;

  always_ff @(posedge global_bus) begin
    if (reset) begin
      stop <= 1'b0;
    end else begin
      stop <= !any_bubble && blocked;  // bubbles never stall
    end
  end

endmodule

// ==== occupancy_tracker.sv ====
// occupancy tracker for the four stations and the reorder buffer
// counts issued entries against completions and retires, derives full flags
`timescale 1ns/1ps
`include "issue_settings.svh"

module occupancy_tracker (
  input  logic        global_bus,
  input  logic        reset,
  instr_info_if.in    issued [2],
  input  logic        stop,
  input  logic        alu_done,
  input  logic        branch_done,
  input  logic        load_store_done,
  input  logic        mult_div_done,
  input  logic [1:0]  rob_retire,
  fullness_if.tracker fullness
);
  import issue_pkg::*;

  localparam station_count_t STATION_MAX   = station_count_t'(`STATION_DEPTH);
  localparam station_count_t STATION_LIMIT = station_count_t'(`STATION_DEPTH - `FULL_MARGIN);
  localparam rob_count_t     ROB_MAX       = rob_count_t'(`ROB_DEPTH);
  localparam rob_count_t     ROB_LIMIT     = rob_count_t'(`ROB_DEPTH - `FULL_MARGIN);

  // station index follows instr_type_t: alu, branch, load/store, mult/div
  station_count_t st_count [4];
  logic [1:0]     st_add [4];
  logic [3:0]     st_done;
  rob_count_t     rob_count;
  logic [1:0]     rob_add;

  instr_type_t    slot_type [2];
  logic [1:0]     slot_real;  // slot holds an instruction

  for (genvar i = 0; i < 2; i++) begin : gen_slot
    assign slot_type[i] = issued[i].instr_type;
    assign slot_real[i] = (issued[i].instr_name != UNKNOWN);
  end

  assign st_done = {mult_div_done, load_store_done, branch_done, alu_done};

  // a held pair was already counted on the edge it appeared
  always_comb begin
    for (int u = 0; u < 4; u++) begin
      st_add[u] = 2'd0;
    end
    rob_add = 2'd0;
    for (int s = 0; s < 2; s++) begin
      if (!stop) begin
        for (int u = 0; u < 4; u++) begin
          if (slot_type[s] == instr_type_t'(u)) st_add[u] = st_add[u] + 2'd1;
        end
        if (slot_real[s]) rob_add = rob_add + 2'd1;
      end
    end
  end

  always_ff @(posedge global_bus) begin
    if (reset) begin
      for (int u = 0; u < 4; u++) begin
        st_count[u] <= '0;
      end
      rob_count <= '0;
    end else begin
      for (int u = 0; u < 4; u++) begin
        st_count[u] <= st_count[u] + station_count_t'(st_add[u])
                       - station_count_t'(st_done[u]);
      end
      rob_count <= rob_count + rob_count_t'(rob_add) - rob_count_t'(rob_retire);
    end
  end

  // depth minus count below the margin, written as count above the limit
  assign fullness.alu        = (st_count[0] > STATION_LIMIT);
  assign fullness.branch     = (st_count[1] > STATION_LIMIT);
  assign fullness.load_store = (st_count[2] > STATION_LIMIT);
  assign fullness.mult_div   = (st_count[3] > STATION_LIMIT);
  assign fullness.rob        = (rob_count > ROB_LIMIT);

  for (genvar u = 0; u < 4; u++) begin : gen_check
    a_done_nonzero: assert property (
      @(posedge global_bus) disable iff (reset) st_done[u] |-> st_count[u] != '0
    );
    a_station_depth: assert property (
      @(posedge global_bus) disable iff (reset) st_count[u] <= STATION_MAX
    );
  end

  a_retire_bound: assert property (
    @(posedge global_bus) disable iff (reset) rob_count_t'(rob_retire) <= rob_count
  );
  a_rob_depth: assert property (
    @(posedge global_bus) disable iff (reset) rob_count <= ROB_MAX
  );

endmodule

// ==== tb_issue_unit.sv ====
// testbench for the issue stage
// random instruction pairs, compared every cycle with a model of issue and occupancy
`timescale 1ns/1ps
`include "issue_settings.svh"

module tb_issue_unit;
  import issue_pkg::*;

  typedef struct packed {
    xlen_t       address;
    xlen_t       immediate;
    instr_name_t name;
    instr_type_t itype;
    regs_t       regs;
    flags_t      flags;
  } slot_t;

  localparam slot_t BUBBLE = '{address: '0, immediate: '0, name: UNKNOWN, itype: XX,
                               regs: '0, flags: '0};

  logic       global_bus;
  logic       reset;
  logic [3:0] done;  // alu, branch, load/store, mult/div
  logic [1:0] rob_retire;
  logic       stop;
  slot_t      stim [2];
  slot_t      act [2];
  slot_t      held [2];
  slot_t      exp_out [2];  // model output register
  bit         exp_stop;
  bit         pending;  // pair on the outputs, not counted yet
  int         st_count [4];
  int         rob_count;
  int         unit;
  int         n;
  string      test_name;
  int         start_errors;
  int         tests_run;
  int         tests_failed;
  int         error_count;

  issue_unit_top issue_unit_top_inst (
    .global_bus      (global_bus),
    .reset           (reset),
    .in0_address     (stim[0].address),   .in1_address     (stim[1].address),
    .in0_immediate   (stim[0].immediate), .in1_immediate   (stim[1].immediate),
    .in0_instr_name  (stim[0].name),      .in1_instr_name  (stim[1].name),
    .in0_instr_type  (stim[0].itype),     .in1_instr_type  (stim[1].itype),
    .in0_regs        (stim[0].regs),      .in1_regs        (stim[1].regs),
    .in0_flags       (stim[0].flags),     .in1_flags       (stim[1].flags),
    .out0_address    (act[0].address),    .out1_address    (act[1].address),
    .out0_immediate  (act[0].immediate),  .out1_immediate  (act[1].immediate),
    .out0_instr_name (act[0].name),       .out1_instr_name (act[1].name),
    .out0_instr_type (act[0].itype),      .out1_instr_type (act[1].itype),
    .out0_regs       (act[0].regs),       .out1_regs       (act[1].regs),
    .out0_flags      (act[0].flags),      .out1_flags      (act[1].flags),
    .alu_done        (done[0]),           .branch_done     (done[1]),
    .load_store_done (done[2]),           .mult_div_done   (done[3]),
    .rob_retire      (rob_retire),
    .stop            (stop)
  );

  initial begin
    global_bus = 1'b0;
    forever #50 global_bus = ~global_bus;
  end

  task automatic compare(input string what, input logic [95:0] expected,
                         input logic [95:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR in %s: %s", test_name, what);
  endtask

  // non-bubble slot with a name that belongs to unit u
  function automatic slot_t random_slot(input int u);
    slot_t s;
    int    pick;
    pick        = $urandom % 3;
    s.address   = $urandom;
    s.immediate = $urandom;
    s.regs      = 15'($urandom);
    s.flags     = 4'($urandom);
    s.itype     = instr_type_t'(3'(u));
    case (u)
      0: s.name = (pick == 0) ? ADD : (pick == 1) ? SUB : AND_OP;
      1: s.name = (pick == 0) ? BEQ : JAL;
      2: s.name = (pick == 0) ? LW : SW;
      default: s.name = (pick == 0) ? MUL : DIV;
    endcase
    return s;
  endfunction

  // index 4 is the reorder buffer, which is also all that type XX meets
  function automatic bit unit_full(input int u);
    if (u == 4) return (`ROB_DEPTH - rob_count) < `FULL_MARGIN;
    return (`STATION_DEPTH - st_count[u]) < `FULL_MARGIN;
  endfunction

  function automatic bit busy();
    return exp_stop || pending || rob_count != 0 || st_count.sum() != 0;
  endfunction

  // model of one rising edge, flags taken from the counts before it
  task automatic model_edge();
    bit blocked;
    blocked = unit_full(int'(stim[0].itype)) || unit_full(int'(stim[1].itype)) ||
              unit_full(4);
    for (int s = 0; s < 2 && pending; s++) begin
      if (exp_out[s].itype != XX) st_count[int'(exp_out[s].itype)]++;
      rob_count++;
    end
    for (int u = 0; u < 4; u++) st_count[u] -= int'(done[u]);
    rob_count -= int'(rob_retire);
    pending = 1'b0;
    if (stim[0].name == UNKNOWN || stim[1].name == UNKNOWN) begin
      exp_out  = '{BUBBLE, BUBBLE};
      exp_stop = 1'b0;
    end else begin
      exp_stop = blocked;
      if (!blocked) begin
        exp_out = stim;
        pending = 1'b1;
      end
    end
  endtask

  task automatic check_dut();
    compare("stop", 96'(exp_stop), 96'(stop));
    compare("slot 0", 96'(exp_out[0]), 96'(act[0]));
    compare("slot 1", 96'(exp_out[1]), 96'(act[1]));
  endtask

  task automatic run_cycle();
    @(posedge global_bus);
    model_edge();
    #1;
    check_dut();
  endtask

  // mode 0 bubble pairs, 1 random pairs, 2 pairs for unit u, 3 idle
  task automatic drive(input int mode, input int u, input int done_pct, input bit retire);
    int k;
    if (!stop) begin  // a stopped pair stays on the inputs
      stim[0] = random_slot((mode == 2) ? u : int'($urandom % 4));
      stim[1] = random_slot((mode == 2) ? u : int'($urandom % 4));
      k = $urandom % 3;
      if (mode == 0 && k != 1) stim[0].name = UNKNOWN;
      if (mode == 0 && k != 0) stim[1].name = UNKNOWN;
      if (mode == 3) stim = '{BUBBLE, BUBBLE};
    end
    for (int i = 0; i < 4; i++) begin
      done[i] = st_count[i] > 0 && (u < 0 || i == u) && int'($urandom % 100) < done_pct;
    end
    rob_retire = !retire ? 2'd0 : (rob_count > 1) ? 2'd2 : 2'(rob_count);
  endtask

  task automatic run_until(input bit want, input int limit, input int mode, input int u,
                           input int done_pct, input bit retire);
    int i;
    for (i = 0; i < limit && stop !== want; i++) begin
      drive(mode, u, done_pct, retire);
      run_cycle();
    end
    if (stop !== want) report_error($sformatf("stop not %0b after %0d cycles", want, limit));
  endtask

  task automatic drain();
    int i;
    for (i = 0; i < 100 && busy(); i++) begin
      drive(3, -1, 100, 1'b1);
      run_cycle();
    end
    if (busy()) report_error("stations and reorder buffer did not drain");
    done       = '0;
    rob_retire = '0;
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    start_errors = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    if (error_count != start_errors) tests_failed++;
    $display("test %s: %s", test_name, (error_count == start_errors) ? "passed" : "failed");
  endtask

  initial begin
    void'($urandom(32'hd235587f));
    reset      = 1'b1;
    stim       = '{BUBBLE, BUBBLE};
    done       = '0;
    rob_retire = '0;
    st_count   = '{default: 0};
    rob_count  = 0;
    exp_out    = '{BUBBLE, BUBBLE};
    repeat (5) @(posedge global_bus);
    #1 reset = 1'b0;

    start_test("reset");
    check_dut();
    run_cycle();
    finish_test();

    start_test("bubble");
    repeat (20) begin
      drive(0, -1, 0, 1'b0);
      run_cycle();
    end
    finish_test();

    start_test("issue");  // no completions, runs until a flag blocks
    run_until(1'b1, 40, 1, -1, 0, 1'b0);
    drain();
    finish_test();

    unit = $urandom % 4;
    start_test("stall");
    run_until(1'b1, 20, 2, unit, 0, 1'b0);
    repeat (3) begin
      drive(2, unit, 0, 1'b0);
      run_cycle();
    end
    finish_test();

    start_test("release");
    held = stim;
    run_until(1'b0, 20, 2, unit, 100, 1'b0);
    compare("released slot 0", 96'(held[0]), 96'(act[0]));
    compare("released slot 1", 96'(held[1]), 96'(act[1]));
    drain();
    finish_test();

    start_test("rob");
    for (n = 0; n < 200 && !(stop && unit_full(4)); n++) begin
      drive(1, -1, 75, 1'b0);
      run_cycle();
    end
    if (!(stop && unit_full(4))) report_error("no stall on the reorder buffer flag");
    run_until(1'b0, 30, 1, -1, 75, 1'b1);  // retire two per cycle
    repeat (40) begin
      drive(1, -1, 75, 1'b1);
      run_cycle();
    end
    drain();
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
